//--- Bender.yml
package:
  name: qtr_array

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/qtr_pkg.sv
      - verilog/qtr_scanner.sv
      - verilog/scan_fifo.sv
      - verilog/line_classifier.sv
      - verilog/qtr_array_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/qtr_sensor_model.sv
      - verif/qtr_tb.sv

//--- list.f
+incdir+verilog
verilog/qtr_pkg.sv
verilog/qtr_scanner.sv
verilog/scan_fifo.sv
verilog/line_classifier.sv
verilog/qtr_array_top.sv
verif/qtr_sensor_model.sv
verif/qtr_tb.sv

//--- verif/qtr_sensor_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module qtr_sensor_model (
    input  wire                          clk,
    input  wire                          qtr_out_en,
    input  wire [`QTR_CHANNELS-1:0]      qtr_out_sig,
    input  wire [`QTR_CHANNELS-1:0][8:0] ticks,
    output logic [`QTR_CHANNELS-1:0]     qtr_in_sig
);

    localparam int CH   = `QTR_CHANNELS;
    localparam int TICK = `QTR_TICK_CYCLES;

    logic [CH-1:0][16:0] remaining = '0;     // clocks until the line reads low

    // the cap charges while driven and starts to drain once the scanner lets go
    always @(posedge clk) begin
        for (int i = 0; i < CH; i++) begin
            if (qtr_out_en === 1'b1) begin
                // half a tick past the last high sample keeps clear of the tick edge
                remaining[i] <= 17'(ticks[i] * TICK + TICK / 2);
            end else if (remaining[i] != '0) begin
                remaining[i] <= remaining[i] - 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < CH; i++) begin
            qtr_in_sig[i] = qtr_out_en ? qtr_out_sig[i] : (remaining[i] != '0);
        end
    end

endmodule

`default_nettype wire

//--- verif/qtr_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module qtr_tb;

    import qtr_pkg::*;

    localparam int CH        = `QTR_CHANNELS;
    localparam int TICK      = `QTR_TICK_CYCLES;
    localparam int NUM_SCANS = 33;
    // every scan may run to the cap and the extra ticks cover the idle and drain phases
    localparam longint WATCHDOG_NS =
        longint'(NUM_SCANS * (`QTR_CHARGE_TICKS + 258) + 40) * TICK * 40;

    logic               clk;
    logic               reset;
    logic               en;
    logic               hold;
    logic [7:0]         threshold;
    logic               qtr_out_en;
    logic [CH-1:0]      qtr_out_sig;
    logic [CH-1:0]      qtr_in_sig;
    line_result_t       result;
    logic               result_valid;
    logic               overflow;
    logic [CH-1:0][8:0] ticks;             // 256 stands for a sensor that never settles
    logic [15:0]        lfsr = 16'd49;
    qtr_scan_t          exp_scans[$];
    line_result_t       exp_results[$];
    int                 held;              // scans parked in the FIFO while hold is high
    logic               exp_overflow;

    qtr_array_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .hold         (hold),
        .threshold    (threshold),
        .qtr_out_en   (qtr_out_en),
        .qtr_out_sig  (qtr_out_sig),
        .qtr_in_sig   (qtr_in_sig),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

    qtr_sensor_model u_sensors (
        .clk         (clk),
        .qtr_out_en  (qtr_out_en),
        .qtr_out_sig (qtr_out_sig),
        .ticks       (ticks),
        .qtr_in_sig  (qtr_in_sig)
    );

    always #20 clk = ~clk;

    // ##########################################################################
    // checks
    // ##########################################################################

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input line_result_t got, input line_result_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED result: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_scan(input qtr_scan_t got, input qtr_scan_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED scan: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED overflow: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_out_sig(input logic [CH-1:0] got, input logic [CH-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED qtr_out_sig: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    // ##########################################################################
    // stimulus and reference model
    // ##########################################################################

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic qtr_scan_t expected_scan(input logic [CH-1:0][8:0] t);
        qtr_scan_t s;
        for (int i = 0; i < CH; i++) begin
            s.timeout[i] = (t[i] >= 9'd255);
            s.value[i]   = s.timeout[i] ? 8'hff : t[i][7:0];
        end
        return s;
    endfunction

    function automatic line_result_t classify(input qtr_scan_t s, input logic [7:0] thr);
        line_result_t r;
        r = '0;
        for (int i = 0; i < CH; i++) begin
            r.dark_mask[i] = (s.value[i] >= thr);
            if (s.value[i] > r.darkest_value) begin    // first maximum is kept
                r.darkest_value   = s.value[i];
                r.darkest_channel = CHAN_IDX_W'(i);
            end
        end
        r.line_found = |r.dark_mask;
        return r;
    endfunction

    task automatic draw_ticks();
        for (int i = 0; i < CH; i++) begin
            ticks[i] = (random_bits(4) == 0) ? 9'd256 : 9'(random_bits(6) % 41);
        end
    endtask

    // one scan per call and en drops as soon as charging starts
    task automatic do_scan(input logic [7:0] thr);
        qtr_scan_t s;
        int        charge_cycles;
        en = 1'b1;
        while (!qtr_out_en) @(negedge clk);
        en = 1'b0;
        charge_cycles = 0;
        while (qtr_out_en) begin
            check_out_sig(qtr_out_sig, '1);
            charge_cycles++;
            @(negedge clk);
        end
        check_out_sig(qtr_out_sig, '0);
        if (charge_cycles != `QTR_CHARGE_TICKS * TICK) begin
            fail_now($sformatf("the sensors were charged for %0d clocks instead of %0d",
                               charge_cycles, `QTR_CHARGE_TICKS * TICK));
        end
        threshold = thr;       // the previous scan was popped long before this point
        s = expected_scan(ticks);
        exp_scans.push_back(s);
        if (hold && (held >= `QTR_FIFO_DEPTH)) begin
            exp_overflow = 1'b1;
        end else begin
            exp_results.push_back(classify(s, thr));
            held = hold ? held + 1 : 0;
        end
    endtask

    task automatic wait_drain();
        while ((exp_scans.size() != 0) || (exp_results.size() != 0)) @(negedge clk);
    endtask

    // every strobe is matched with the oldest expected entry
    always @(negedge clk) begin
        if (!reset && u_dut.scan_valid) begin
            if (exp_scans.size() == 0) begin
                fail_now("a scan finished when none was started");
            end else begin
                check_scan(u_dut.scan, exp_scans.pop_front());
            end
        end
        if (!reset && result_valid) begin
            if (exp_results.size() == 0) begin
                fail_now("result_valid pulsed with no result expected");
            end else begin
                check_result(result, exp_results.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("timeout: the scans did not all finish in the expected time");
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        en           = 1'b0;
        hold         = 1'b0;
        threshold    = 8'd0;
        ticks        = '0;
        held         = 0;
        exp_overflow = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        repeat (3 * TICK) begin
            @(negedge clk);
            if (qtr_out_en !== 1'b0) begin
                fail_now("qtr_out_en was driven before en rose");
            end
            check_out_sig(qtr_out_sig, '0);
        end
        check_overflow(overflow, 1'b0);

        repeat (24) begin
            draw_ticks();
            do_scan(8'(random_bits(6)));
        end

        ticks = {9'd3, 9'd256, 9'd256, 9'd12};     // channels 1 and 2 never discharge
        do_scan(8'd20);
        ticks = {9'd0, 9'd9, 9'd2, 9'd5};
        do_scan(8'd30);
        do_scan(8'd0);
        wait_drain();
        check_overflow(overflow, 1'b0);

        // ##########################################################################
        // back-pressure fills the FIFO and drops the rest
        // ##########################################################################
        hold = 1'b1;
        repeat (6) begin
            draw_ticks();
            do_scan(8'd16);
        end
        while (exp_scans.size() != 0) @(negedge clk);
        @(negedge clk);
        hold = 1'b0;
        wait_drain();
        repeat (4 * (CH + 1)) @(negedge clk);      // any extra result would show up here
        check_overflow(overflow, exp_overflow);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/line_classifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module line_classifier (
    input  wire                     clk,
    input  wire                     reset,
    input  wire qtr_pkg::qtr_scan_t head,
    input  wire                     empty,
    input  wire                     hold,
    input  wire [7:0]               threshold,
    output logic                    pop,
    output qtr_pkg::line_result_t   result,
    output logic                    result_valid
);

    import qtr_pkg::*;

    localparam int CH = `QTR_CHANNELS;

    logic                  busy;
    logic [CHAN_IDX_W-1:0] idx;            // channel compared this cycle
    logic                  last;
    logic [CH-1:0][7:0]    vals;
    logic [7:0]            thr;
    logic [7:0]            cur;
    logic [CH-1:0]         mask;
    logic [CH-1:0]         mask_next;
    logic [7:0]            best_val;
    logic [7:0]            best_val_next;
    logic [CHAN_IDX_W-1:0] best_idx;
    logic [CHAN_IDX_W-1:0] best_idx_next;

    // one scan at a time while the rest wait in the FIFO
    assign pop  = !busy && !empty && !hold;
    assign cur  = vals[idx];
    assign last = (idx == CHAN_IDX_W'(CH - 1));

    // ##########################################################################
    // per-channel compare
    // ##########################################################################

    always_comb begin
        mask_next      = mask;
        mask_next[idx] = (cur >= thr);
        best_val_next  = best_val;
        best_idx_next  = best_idx;
        // strict compare keeps the lower index on a tie
        if (cur > best_val) begin
            best_val_next = cur;
            best_idx_next = idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            idx          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (pop) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                if (last) begin
                    busy         <= 1'b0;
                    result_valid <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // threshold is taken with the record so a change mid-walk has no effect
    always_ff @(posedge clk) begin
        if (pop) begin
            vals     <= head.value;
            thr      <= threshold;
            mask     <= '0;
            best_val <= 8'd0;
            best_idx <= '0;
        end else if (busy) begin
            mask     <= mask_next;
            best_val <= best_val_next;
            best_idx <= best_idx_next;
            if (last) begin
                result.dark_mask       <= mask_next;
                result.darkest_channel <= best_idx_next;
                result.darkest_value   <= best_val_next;
                result.line_found      <= |mask_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/qtr_array_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module qtr_array_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          en,
    input  wire                          hold,
    input  wire [7:0]                    threshold,
    output wire                          qtr_out_en,
    output wire [`QTR_CHANNELS-1:0]      qtr_out_sig,
    input  wire [`QTR_CHANNELS-1:0]      qtr_in_sig,
    output wire qtr_pkg::line_result_t   result,
    output wire                          result_valid,
    output wire                          overflow
);

    import qtr_pkg::*;

    wire qtr_scan_t scan;
    wire            scan_valid;
    wire qtr_scan_t head;
    wire            empty;
    wire            pop;

    // ##########################################################################
    // scanner feeds the FIFO, classifier drains it
    // ##########################################################################

    qtr_scanner u_scanner (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .qtr_in_sig  (qtr_in_sig),
        .qtr_out_en  (qtr_out_en),
        .qtr_out_sig (qtr_out_sig),
        .scan        (scan),
        .scan_valid  (scan_valid)
    );

    scan_fifo #(
        .DEPTH (`QTR_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .scan       (scan),
        .scan_valid (scan_valid),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .overflow   (overflow)
    );

    line_classifier u_classifier (
        .clk          (clk),
        .reset        (reset),
        .head         (head),
        .empty        (empty),
        .hold         (hold),          // scans pile up in the FIFO while the host holds off
        .threshold    (threshold),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- verilog/qtr_macros.svh
`ifndef QTR_MACROS_SVH
`define QTR_MACROS_SVH

// system clock in Hz
`define QTR_CLK_FREQUENCY 25_000_000

// clock cycles in one 10 us tick
`define QTR_TICK_CYCLES (`QTR_CLK_FREQUENCY / 100_000)

`define QTR_CHANNELS 4        // sensors read side by side

// ticks the sensor caps are charged before timing starts
`define QTR_CHARGE_TICKS 1

`define QTR_FIFO_DEPTH 4      // scans buffered between scanner and classifier

`endif

//--- verilog/qtr_pkg.sv
`default_nettype none

`include "qtr_macros.svh"

package qtr_pkg;

    // a channel index is at least one bit wide even for a single sensor
    localparam int CHAN_IDX_W = (`QTR_CHANNELS > 1) ? $clog2(`QTR_CHANNELS) : 1;

    // ##########################################################################
    // one finished scan
    // ##########################################################################

    // value[i] is the number of ticks channel i was seen high, capped at 255
    typedef struct packed {
        logic [`QTR_CHANNELS-1:0][7:0] value;
        logic [`QTR_CHANNELS-1:0]      timeout;     // channel hit the 255 cap
    } qtr_scan_t;

    // ##########################################################################
    // one classified scan
    // ##########################################################################

    typedef struct packed {
        logic [`QTR_CHANNELS-1:0] dark_mask;        // value at or above threshold
        logic [CHAN_IDX_W-1:0]    darkest_channel;  // lowest index wins a tie
        logic [7:0]               darkest_value;
        logic                     line_found;       // at least one dark channel
    } line_result_t;

endpackage

`default_nettype wire

//--- verilog/qtr_scanner.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module qtr_scanner (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      en,
    input  wire [`QTR_CHANNELS-1:0]  qtr_in_sig,
    output logic                     qtr_out_en,
    output logic [`QTR_CHANNELS-1:0] qtr_out_sig,
    output qtr_pkg::qtr_scan_t       scan,
    output logic                     scan_valid
);

    localparam int CH     = `QTR_CHANNELS;
    localparam int TICK_W = $clog2(`QTR_TICK_CYCLES);
    localparam int CHG_W  = $clog2(`QTR_CHARGE_TICKS + 1);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_CHARGE = 2'd1;
    localparam logic [1:0] S_TIME   = 2'd2;

    logic [1:0]         state;
    logic [TICK_W-1:0]  div_cnt;
    logic               tick;
    logic [CHG_W-1:0]   charge_cnt;
    logic [CH-1:0][7:0] cnt;
    logic [CH-1:0][7:0] cnt_next;
    logic [CH-1:0]      still_high;       // high and not yet at the cap
    logic [CH-1:0]      timed_out;
    logic               settled;
    logic               start;

    // a new scan needs every line low, otherwise a sensor is still discharging
    assign start = en && (qtr_in_sig == '0);
    assign tick  = (div_cnt == TICK_W'(`QTR_TICK_CYCLES - 1));

    // ##########################################################################
    // 10 us tick divider
    // ##########################################################################

    // held at zero while idle so the first tick lands a full period after start
    always_ff @(posedge clk) begin
        if (reset || (state == S_IDLE)) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ##########################################################################
    // per-channel discharge counters
    // ##########################################################################

    always_comb begin
        for (int i = 0; i < CH; i++) begin
            cnt_next[i]   = cnt[i] + {7'd0, qtr_in_sig[i] && (cnt[i] != 8'hff)};
            still_high[i] = qtr_in_sig[i] && (cnt_next[i] != 8'hff);
            timed_out[i]  = (cnt_next[i] == 8'hff);
        end
    end

    // done once every line has dropped or is stuck at the cap
    assign settled = (still_high == '0);

    always_ff @(posedge clk) begin
        if (state == S_CHARGE) begin
            cnt <= '0;
        end else if ((state == S_TIME) && tick) begin
            cnt <= cnt_next;                // a fallen channel simply stops counting
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_TIME) && tick && settled) begin
            scan.value   <= cnt_next;
            scan.timeout <= timed_out;
        end
    end

    // ##########################################################################
    // measurement FSM
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            qtr_out_en  <= 1'b0;
            qtr_out_sig <= '0;
            scan_valid  <= 1'b0;
            charge_cnt  <= '0;
        end else begin
            scan_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state       <= S_CHARGE;
                        qtr_out_en  <= 1'b1;    // drive every sensor high
                        qtr_out_sig <= '1;
                        charge_cnt  <= '0;
                    end
                end
                S_CHARGE: begin
                    if (tick) begin
                        if (charge_cnt == CHG_W'(`QTR_CHARGE_TICKS - 1)) begin
                            state       <= S_TIME;
                            qtr_out_en  <= 1'b0;    // release so the lines read back
                            qtr_out_sig <= '0;
                        end else begin
                            charge_cnt <= charge_cnt + 1'b1;
                        end
                    end
                end
                S_TIME: begin
                    if (tick && settled) begin
                        state      <= S_IDLE;
                        scan_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/scan_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "qtr_macros.svh"

module scan_fifo #(
    parameter int DEPTH = `QTR_FIFO_DEPTH
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire qtr_pkg::qtr_scan_t scan,
    input  wire                     scan_valid,
    input  wire                     pop,
    output qtr_pkg::qtr_scan_t      head,
    output logic                    empty,
    output logic                    overflow
);

    import qtr_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    qtr_scan_t          mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               push;
    logic               take;

    // pointers wrap by compare so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign push  = scan_valid && !full;     // a scan arriving while full is lost
    assign take  = pop && !empty;
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= scan;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither leave the level alone
            endcase
            if (scan_valid && full) begin
                overflow <= 1'b1;           // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire
